// File: all.f
+incdir+rtl
rtl/knightPkg.sv
rtl/cmdIf.sv
rtl/uartXcvr.sv
rtl/cmdWrapper.sv
rtl/cmdProc.sv
rtl/knightTop.sv
dv/knightChecker.sv
dv/knightTour_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the knight controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -Mdir obj_dir --top-module knightTour_tb -o simv -f all.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" sim.log; then
  exit 1
fi
exit 0

// File: dv/knightTour_tb.sv
`timescale 1ns/100ps
`include "knight_cfg.svh"

module knightTour_tb;

  // One command with its expected outcome
  typedef struct packed {
    logic [15:0] cmd;
    logic [7:0]  resp;
    logic [2:0]  x;
    logic [2:0]  y;
    logic        cal;
  } rowT;

  localparam int numRows = 12;
  localparam int calWaitMax = 200;
  localparam int respWaitMax = 2000;
  // Quiet time at the end to catch stray frames
  localparam int tailCycles = 40 * `BAUD_DIV;

  logic       clk;
  logic       rstN;
  logic       rx;
  logic       calDone;
  logic       tx;
  logic       strtCal;
  logic       moving;
  logic [2:0] xx;
  logic [2:0] yy;

  // Current row as seen by the checker
  logic [15:0] expCmd;
  logic [7:0]  expResp;
  logic [2:0]  expX;
  logic [2:0]  expY;
  logic        expCal;
  int          sentCnt;
  int          respCnt;
  int          mismatchCnt;
  int          failCnt;
  int          tbFails;
  logic [7:0]  lfsrState;
  rowT         rows [numRows];

  knightTop dut_i (
    .clk     (clk),
    .rstN    (rstN),
    .rx      (rx),
    .calDone (calDone),
    .tx      (tx),
    .strtCal (strtCal),
    .moving  (moving),
    .xx      (xx),
    .yy      (yy)
  );

  knightChecker chk_i (
    .clk         (clk),
    .rstN        (rstN),
    .tx          (tx),
    .strtCal     (strtCal),
    .moving      (moving),
    .xx          (xx),
    .yy          (yy),
    .calDone     (calDone),
    .expCmd      (expCmd),
    .expResp     (expResp),
    .expX        (expX),
    .expY        (expY),
    .expCal      (expCal),
    .sentCnt     (sentCnt),
    .respCnt     (respCnt),
    .mismatchCnt (mismatchCnt),
    .failCnt     (failCnt)
  );

  always #2 clk = ~clk;

  ////////////////////
  // Stimulus table
  ////////////////////

  // Walk from (2,2)
  // x grows east and y grows north
  task automatic loadTable();
    rows[0]  = '{16'h2000, `POS_ACK, 3'd2, 3'd2, 1'b1};
    rows[1]  = '{16'h43F2, `POS_ACK, 3'd0, 3'd2, 1'b0};
    rows[2]  = '{16'h4002, `POS_ACK, 3'd0, 3'd4, 1'b0};
    rows[3]  = '{16'h4BF3, `POS_ACK, 3'd3, 3'd4, 1'b0};
    rows[4]  = '{16'h47F1, `POS_ACK, 3'd3, 3'd3, 1'b0};
    // West 4 from x = 3 leaves the board
    rows[5]  = '{16'h43F4, `NEG_ACK, 3'd3, 3'd3, 1'b0};
    rows[6]  = '{16'h7000, `NEG_ACK, 3'd3, 3'd3, 1'b0};
    rows[7]  = '{16'h4551, `NEG_ACK, 3'd3, 3'd3, 1'b0};
    rows[8]  = '{16'h4BF0, `NEG_ACK, 3'd3, 3'd3, 1'b0};
    // North 2 from y = 3 lands on y = 5
    rows[9]  = '{16'h4002, `NEG_ACK, 3'd3, 3'd3, 1'b0};
    rows[10] = '{16'h4BF1, `POS_ACK, 3'd4, 3'd3, 1'b0};
    rows[11] = '{16'h2000, `POS_ACK, 3'd4, 3'd3, 1'b1};
  endtask

  ////////////////////
  // Remote and gyro models
  ////////////////////

  // Galois LFSR with taps x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] nextLfsr(input logic [7:0] s);
    return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
  endfunction

  task automatic drawBits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      val = (val << 1) | int'(lfsrState[0]);
      lfsrState = nextLfsr(lfsrState);
    end
  endtask

  // 8N1 frame with LSB first
  task automatic sendByte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rx <= frame[0];
      frame = frame >> 1;
      repeat (`BAUD_DIV) @(posedge clk);
    end
  endtask

  // Gyro stand-in answering strtCal after a random delay
  task automatic respondToCal(output bit ok);
    int waited;
    int delay;
    ok = 1'b0;
    waited = 0;
    while (!ok && waited < calWaitMax) begin
      @(posedge clk);
      if (strtCal)
        ok = 1'b1;
      waited++;
    end
    if (!ok) begin
      $display("TIMEOUT: no strtCal pulse within %0d cycles", calWaitMax);
      tbFails++;
    end else begin
      drawBits(6, delay);
      repeat (delay + 2) @(posedge clk);
      calDone <= 1'b1;
      @(posedge clk);
      calDone <= 1'b0;
    end
  endtask

  task automatic waitResponse(input int target, output bit ok);
    int waited;
    ok = 1'b0;
    waited = 0;
    while (!ok && waited < respWaitMax) begin
      @(posedge clk);
      if (respCnt >= target)
        ok = 1'b1;
      waited++;
    end
    if (!ok) begin
      $display("TIMEOUT: no response frame for command %0d within %0d cycles",
               target - 1, respWaitMax);
      tbFails++;
    end
  endtask

  initial begin
    bit ok;
    bit aborted;
    clk = 1'b0;
    rstN = 1'b0;
    rx = 1'b1;
    calDone = 1'b0;
    expCmd = '0;
    expResp = '0;
    expX = `START_XX;
    expY = `START_YY;
    expCal = 1'b0;
    sentCnt = 0;
    tbFails = 0;
    lfsrState = 8'd56;
    aborted = 1'b0;
    loadTable();
    repeat (10) @(posedge clk);
    rstN <= 1'b1;
    repeat (4) @(posedge clk);
    for (int r = 0; r < numRows && !aborted; r++) begin
      expCmd  <= rows[r].cmd;
      expResp <= rows[r].resp;
      expX    <= rows[r].x;
      expY    <= rows[r].y;
      expCal  <= rows[r].cal;
      sentCnt <= sentCnt + 1;
      sendByte(rows[r].cmd[15:8]);
      sendByte(rows[r].cmd[7:0]);
      ok = 1'b1;
      if (rows[r].cal)
        respondToCal(ok);
      if (ok)
        waitResponse(r + 1, ok);
      aborted = !ok;
      // Let the DUT return to idle before the next command
      repeat (2 * `BAUD_DIV) @(posedge clk);
    end
    if (!aborted)
      repeat (tailCycles) @(posedge clk);
    $display("Error counts: %0d mismatches, %0d other failures",
             mismatchCnt, failCnt + tbFails);
    if (mismatchCnt == 0 && failCnt == 0 && tbFails == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

// File: dv/knightChecker.sv
`timescale 1ns/100ps
`include "knight_cfg.svh"

module knightChecker
  import knightPkg::*;
(
  input  logic        clk,
  input  logic        rstN,
  input  logic        tx,
  input  logic        strtCal,
  input  logic        moving,
  input  logic [2:0]  xx,
  input  logic [2:0]  yy,
  input  logic        calDone,
  input  logic [15:0] expCmd,
  input  logic [7:0]  expResp,
  input  logic [2:0]  expX,
  input  logic [2:0]  expY,
  input  logic        expCal,
  input  int          sentCnt,
  output int          respCnt,
  output int          mismatchCnt,
  output int          failCnt
);

  // Running totals, published once per clock
  int mmNow = 0;
  int failNow = 0;
  int respNow = 0;

  // Activity seen since the last response frame
  int calCyc = 0;
  int moveCyc = 0;
  int calDoneCyc = 0;

  // tx frame decoder
  bit         frameOn = 1'b0;
  int         baudCnt = 0;
  int         bitIdx = 0;
  logic [7:0] frameByte;
  bit         resetChecked = 1'b0;

  task automatic compareVal(input string name, input int expV, input int actV);
    if (expV != actV) begin
      $display("MISMATCH at %0t: %s expected %0h, actual %0h", $time, name, expV, actV);
      mmNow++;
    end
  endtask

  task automatic reportFailure(input string msg);
    $display("FAILURE at %0t: %s", $time, msg);
    failNow++;
  endtask

  // Moving only for an accepted move, squares times cycles per square
  function automatic int expMoveCyc();
    if (opcodeT'(expCmd[15:12]) == MOVE && expResp == `POS_ACK)
      return int'(expCmd[3:0]) * `MOVE_CYC_PER_SQ;
    return 0;
  endfunction

  ////////////////////
  // Response frame
  ////////////////////

  task automatic checkFrame();
    if (respNow >= sentCnt) begin
      reportFailure("response frame on tx with no command pending");
    end else begin
      compareVal("resp", int'(expResp), int'(frameByte));
      compareVal("xx", int'(expX), int'(xx));
      compareVal("yy", int'(expY), int'(yy));
      compareVal("strtCal high cycles", expCal ? 1 : 0, calCyc);
      compareVal("moving high cycles", expMoveCyc(), moveCyc);
      // Calibration must finish before its answer
      if (expCal && calDoneCyc == 0)
        reportFailure("calibration response arrived before calDone");
      respNow++;
    end
    calCyc = 0;
    moveCyc = 0;
    calDoneCyc = 0;
  endtask

  always @(posedge clk) begin
    if (!rstN) begin
      frameOn = 1'b0;
      calCyc = 0;
      moveCyc = 0;
      calDoneCyc = 0;
    end else begin
      // Idle state right after reset
      if (!resetChecked) begin
        compareVal("xx", int'(`START_XX), int'(xx));
        compareVal("yy", int'(`START_YY), int'(yy));
        compareVal("tx", 1, int'(tx));
        compareVal("moving", 0, int'(moving));
        compareVal("strtCal", 0, int'(strtCal));
        resetChecked = 1'b1;
      end
      if (strtCal)
        calCyc++;
      if (moving)
        moveCyc++;
      if (calDone)
        calDoneCyc++;
      // 8N1 decode, sampled near mid-bit
      if (!frameOn) begin
        if (!tx) begin
          frameOn = 1'b1;
          baudCnt = `BAUD_DIV / 2 - 1;
          bitIdx = 0;
        end
      end else if (baudCnt > 0) begin
        baudCnt--;
      end else begin
        baudCnt = `BAUD_DIV - 1;
        if (bitIdx == 0) begin
          // Start bit gone, treat as glitch
          if (tx)
            frameOn = 1'b0;
        end else if (bitIdx <= 8) begin
          frameByte = {tx, frameByte[7:1]};
        end else begin
          frameOn = 1'b0;
          if (!tx)
            reportFailure("stop bit missing on tx");
          else
            checkFrame();
        end
        bitIdx++;
      end
    end
    respCnt     <= respNow;
    mismatchCnt <= mmNow;
    failCnt     <= failNow;
  end

endmodule

// File: rtl/knightTop.sv
`timescale 1ns/100ps

module knightTop (
  input  logic       clk,
  input  logic       rstN,
  input  logic       rx,
  input  logic       calDone,
  output logic       tx,
  output logic       strtCal,
  output logic       moving,
  output logic [2:0] xx,
  output logic [2:0] yy
);

  // Receive stream
  logic [7:0] rxData;
  logic       rxRdy;
  logic       clrRxRdy;
  // Transmit stream
  logic [7:0] txData;
  logic       trmt;
  logic       txDone;

  // Command and response between wrapper and processor
  cmdIf cif ();

  // Serial line
  uartXcvr uart_i (
    .clk      (clk),
    .rstN     (rstN),
    .rx       (rx),
    .txData   (txData),
    .trmt     (trmt),
    .clrRxRdy (clrRxRdy),
    .tx       (tx),
    .txDone   (txDone),
    .rxData   (rxData),
    .rxRdy    (rxRdy)
  );

  // Bytes to commands and back
  cmdWrapper wrap_i (
    .clk      (clk),
    .rstN     (rstN),
    .rxData   (rxData),
    .rxRdy    (rxRdy),
    .txDone   (txDone),
    .clrRxRdy (clrRxRdy),
    .txData   (txData),
    .trmt     (trmt),
    .cif      (cif.wrap)
  );

  // Decode, calibrate, move, track the knight
  cmdProc proc_i (
    .clk     (clk),
    .rstN    (rstN),
    .calDone (calDone),
    .strtCal (strtCal),
    .moving  (moving),
    .xx      (xx),
    .yy      (yy),
    .cif     (cif.proc)
  );

endmodule

// File: rtl/cmdProc.sv
`timescale 1ns/100ps
`include "knight_cfg.svh"

module cmdProc
  import knightPkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  input  logic       calDone,
  output logic       strtCal,
  output logic       moving,
  output logic [2:0] xx,
  output logic [2:0] yy,
  cmdIf.proc         cif
);

  procStateT state;
  // Second cycle of command intake
  logic      decode;

  // Command fields
  opcodeT    op;
  headingT   hd;
  logic [3:0] sq;

  // Signed target arithmetic, one sign bit and room for overflow
  logic signed [5:0] xExt;
  logic signed [5:0] yExt;
  logic signed [5:0] sqExt;
  logic signed [5:0] tgtX;
  logic signed [5:0] tgtY;
  logic              hdOk;
  logic              onBoard;
  logic              moveOk;

  // Remaining cycles of the move phase
  logic [15:0] moveCnt;
  // Destination square latched at decode
  logic [2:0]  dstX;
  logic [2:0]  dstY;

  assign op = opcodeT'(cif.cmd[15:12]);
  assign hd = headingT'(cif.cmd[11:4]);
  assign sq = cif.cmd[3:0];

  ////////////////////
  // Target square
  ////////////////////

  assign xExt  = $signed({3'b000, xx});
  assign yExt  = $signed({3'b000, yy});
  assign sqExt = $signed({2'b00, sq});

  always_comb begin
    hdOk = 1'b1;
    tgtX = xExt;
    tgtY = yExt;
    case (hd)
      NORTH: tgtY = yExt + sqExt;
      SOUTH: tgtY = yExt - sqExt;
      WEST:  tgtX = xExt - sqExt;
      EAST:  tgtX = xExt + sqExt;
      // Heading outside the four compass points
      default: hdOk = 1'b0;
    endcase
  end

  assign onBoard = (tgtX >= 6'sd0) && (tgtX < $signed(6'(`BOARD_SIZE))) &&
                   (tgtY >= 6'sd0) && (tgtY < $signed(6'(`BOARD_SIZE)));

  assign moveOk = (op == MOVE) && hdOk && (sq != 4'd0) && onBoard;

  // Take the command while idle, cmdRdy drops next cycle
  assign cif.clrCmdRdy = (state == IDLE) && cif.cmdRdy && !decode;

  // High for exactly the move phase
  assign moving = (state == MOVE_PH);

  ////////////////////
  // Control FSM
  ////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state        <= IDLE;
      decode       <= 1'b0;
      strtCal      <= 1'b0;
      cif.sendResp <= 1'b0;
      moveCnt      <= '0;
      xx           <= `START_XX;
      yy           <= `START_YY;
    end else begin
      strtCal      <= 1'b0;
      cif.sendResp <= 1'b0;
      decode       <= cif.clrCmdRdy;
      case (state)
        IDLE: begin
          if (decode) begin
            if (op == CALIBRATE) begin
              strtCal <= 1'b1;
              state   <= CAL;
            end else if (moveOk) begin
              moveCnt <= 16'(sq * `MOVE_CYC_PER_SQ);
              state   <= MOVE_PH;
            end else begin
              // Rejected, answer at once
              cif.sendResp <= 1'b1;
              state        <= RESP;
            end
          end
        end
        CAL: begin
          // No timeout, gyro side decides
          if (calDone) begin
            cif.sendResp <= 1'b1;
            state        <= RESP;
          end
        end
        MOVE_PH: begin
          if (moveCnt == 16'd1) begin
            // Arrived, position changes as moving falls
            xx           <= dstX;
            yy           <= dstY;
            cif.sendResp <= 1'b1;
            state        <= RESP;
          end else begin
            moveCnt <= moveCnt - 16'd1;
          end
        end
        RESP: begin
          if (cif.respSent)
            state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  ////////////////////
  // Payload
  ////////////////////

  always_ff @(posedge clk) begin
    if (state == IDLE && decode) begin
      dstX     <= tgtX[2:0];
      dstY     <= tgtY[2:0];
      cif.resp <= (op == CALIBRATE || moveOk) ? `POS_ACK : `NEG_ACK;
    end
  end

endmodule

// File: rtl/cmdWrapper.sv
`timescale 1ns/100ps

module cmdWrapper (
  input  logic       clk,
  input  logic       rstN,
  input  logic [7:0] rxData,
  input  logic       rxRdy,
  input  logic       txDone,
  output logic       clrRxRdy,
  output logic [7:0] txData,
  output logic       trmt,
  cmdIf.wrap         cif
);

  typedef enum logic {
    WAIT_HI = 1'b0,
    WAIT_LO = 1'b1
  } pairStateT;

  pairStateT  pairSt;
  logic [7:0] hiByte;
  // Command held from pairing until its response is out
  logic       busy;
  // First cycle of a fresh rxRdy
  logic       rxNew;

  assign rxNew = rxRdy && !clrRxRdy;

  ////////////////////
  // Byte pairing
  ////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pairSt     <= WAIT_HI;
      clrRxRdy   <= 1'b0;
      cif.cmdRdy <= 1'b0;
      busy       <= 1'b0;
    end else begin
      // Acknowledge each byte one cycle after rxRdy
      clrRxRdy <= rxNew;
      if (cif.clrCmdRdy)
        cif.cmdRdy <= 1'b0;
      if (txDone)
        busy <= 1'b0;
      if (rxNew) begin
        if (busy) begin
          // Drop the byte, pairing starts over
          pairSt <= WAIT_HI;
        end else if (pairSt == WAIT_HI) begin
          pairSt <= WAIT_LO;
        end else begin
          pairSt     <= WAIT_HI;
          cif.cmdRdy <= 1'b1;
          busy       <= 1'b1;
        end
      end
    end
  end

  // High byte first, low byte completes the command
  always_ff @(posedge clk) begin
    if (rxNew && !busy) begin
      if (pairSt == WAIT_HI)
        hiByte <= rxData;
      else
        cif.cmd <= {hiByte, rxData};
    end
  end

  ////////////////////
  // Response path
  ////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      trmt         <= 1'b0;
      cif.respSent <= 1'b0;
    end else begin
      trmt         <= cif.sendResp;
      cif.respSent <= txDone;
    end
  end

  always_ff @(posedge clk) begin
    if (cif.sendResp)
      txData <= cif.resp;
  end

endmodule

// File: rtl/uartXcvr.sv
`timescale 1ns/100ps
`include "knight_cfg.svh"

module uartXcvr (
  input  logic       clk,
  input  logic       rstN,
  input  logic       rx,
  input  logic [7:0] txData,
  input  logic       trmt,
  input  logic       clrRxRdy,
  output logic       tx,
  output logic       txDone,
  output logic [7:0] rxData,
  output logic       rxRdy
);

  // Baud counter width, wide enough for BAUD_DIV - 1
  localparam int baudW = $clog2(`BAUD_DIV + 1);
  localparam logic [baudW-1:0] baudMax = baudW'(`BAUD_DIV - 1);
  // Countdown from start edge to middle of the start bit
  localparam logic [baudW-1:0] halfMax = baudW'(`BAUD_DIV / 2 - 1);

  typedef enum logic {
    RX_IDLE = 1'b0,
    RX_RECV = 1'b1
  } rxStateT;

  ////////////////////
  // Receiver
  ////////////////////

  rxStateT          rxState;
  logic             rxMeta;
  logic             rxSync;
  logic [baudW-1:0] rxBaud;
  // Bit index, 0 start, 1..8 data, 9 stop
  logic [3:0]       rxBit;
  logic [7:0]       rxShift;
  logic             rxSample;

  // Two flops against metastability, idle high
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rxMeta <= 1'b1;
      rxSync <= 1'b1;
    end else begin
      rxMeta <= rx;
      rxSync <= rxMeta;
    end
  end

  // Mid-bit strobe
  assign rxSample = (rxState == RX_RECV) && (rxBaud == '0);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rxState <= RX_IDLE;
      rxBaud  <= '0;
      rxBit   <= '0;
      rxRdy   <= 1'b0;
    end else begin
      if (clrRxRdy)
        rxRdy <= 1'b0;
      case (rxState)
        RX_IDLE: begin
          // Falling edge on the line starts a frame
          if (!rxSync) begin
            rxState <= RX_RECV;
            rxBaud  <= halfMax;
            rxBit   <= '0;
          end
        end
        RX_RECV: begin
          if (rxSample) begin
            rxBaud <= baudMax;
            rxBit  <= rxBit + 4'd1;
            // Glitch, start bit no longer low at mid-bit
            if (rxBit == 4'd0 && rxSync)
              rxState <= RX_IDLE;
            // Stop bit, byte only valid when the line is high
            if (rxBit == 4'd9) begin
              rxState <= RX_IDLE;
              if (rxSync)
                rxRdy <= 1'b1;
            end
          end else begin
            rxBaud <= rxBaud - 1'b1;
          end
        end
        default: rxState <= RX_IDLE;
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (rxSample && rxBit >= 4'd1 && rxBit <= 4'd8)
      rxShift <= {rxSync, rxShift[7:1]};
    if (rxSample && rxBit == 4'd9 && rxSync)
      rxData <= rxShift;
  end

  ////////////////////
  // Transmitter
  ////////////////////

  logic             txBusy;
  logic [baudW-1:0] txBaud;
  logic [3:0]       txBit;
  // Stop, data, start, shifted out from bit 0
  logic [9:0]       txShift;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      txBusy  <= 1'b0;
      txBaud  <= '0;
      txBit   <= '0;
      txShift <= '1;
      txDone  <= 1'b0;
    end else begin
      txDone <= 1'b0;
      if (!txBusy) begin
        // New byte, ignored while a frame is in flight
        if (trmt) begin
          txBusy  <= 1'b1;
          txBaud  <= baudMax;
          txBit   <= '0;
          txShift <= {1'b1, txData, 1'b0};
        end
      end else if (txBaud == '0) begin
        txBaud  <= baudMax;
        // Shift in ones so the line rests high
        txShift <= {1'b1, txShift[9:1]};
        if (txBit == 4'd9) begin
          txBusy <= 1'b0;
          txDone <= 1'b1;
        end else begin
          txBit <= txBit + 4'd1;
        end
      end else begin
        txBaud <= txBaud - 1'b1;
      end
    end
  end

  assign tx = txShift[0];

endmodule

// File: rtl/cmdIf.sv
`timescale 1ns/100ps

interface cmdIf;

  // Assembled 16-bit command and its valid flag
  logic [15:0] cmd;
  logic        cmdRdy;
  // Processor acknowledges the command
  logic        clrCmdRdy;

  // One response byte per command
  logic [7:0]  resp;
  // Pulse with resp valid
  logic        sendResp;
  // Pulse once the byte has left the tx line
  logic        respSent;

  // UART side, owns the command and the sent flag
  modport wrap (
    output cmd, cmdRdy, respSent,
    input  clrCmdRdy, resp, sendResp
  );

  // Command processor side
  modport proc (
    input  cmd, cmdRdy, respSent,
    output clrCmdRdy, resp, sendResp
  );

endinterface

// File: rtl/knightPkg.sv
package knightPkg;

  ////////////////////
  // Command fields
  ////////////////////

  // Opcode in cmd[15:12]
  // Any value not listed here is rejected
  typedef enum logic [3:0] {
    CALIBRATE = 4'h2,
    MOVE      = 4'h4
  } opcodeT;

  // Heading in cmd[11:4]
  // North and south change yy, west and east change xx
  typedef enum logic [7:0] {
    NORTH = 8'h00,
    WEST  = 8'h3F,
    SOUTH = 8'h7F,
    EAST  = 8'hBF
  } headingT;

  ////////////////////
  // Processor FSM
  ////////////////////

  // Idle / waiting on calibration / timed move phase / response pending
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    CAL     = 2'd1,
    MOVE_PH = 2'd2,
    RESP    = 2'd3
  } procStateT;

endpackage

// File: rtl/knight_cfg.svh
`ifndef KNIGHT_CFG_SVH
`define KNIGHT_CFG_SVH

////////////////////
// UART timing
////////////////////

// Clock cycles per UART bit
`define BAUD_DIV 8

////////////////////
// Motion timing
////////////////////

// Cycles of the moving phase for each square travelled
`define MOVE_CYC_PER_SQ 32

////////////////////
// Board geometry
////////////////////

// Edge length of the square board, positions are 3 bits wide
`define BOARD_SIZE 5

// Square occupied after reset
`define START_XX 3'd2
`define START_YY 3'd2

////////////////////
// Response bytes
////////////////////

// Command accepted and completed
`define POS_ACK 8'hA5
// Command rejected, nothing done
`define NEG_ACK 8'h5A

`endif
